//--- Bender.yml
package:
  name: keypad_calc

sources:
  - logic/calc_data_pkg.sv
  - logic/calc_ctrl_pkg.sv
  - logic/digit_entry.sv
  - logic/add_sub_unit.sv
  - logic/seq_multiplier.sv
  - logic/calc_controller.sv
  - logic/calc_top.sv
  - target: simulation
    files:
      - dv/calc_props.sv
      - dv/calc_tb.sv

//--- dv/calc_props.sv
`timescale 1ns/1ns

module calc_props
    import calc_data_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input logic     clk,
    input logic     nRST,
    input logic     complete,
    input logic     add_start,
    input logic     mult_start,
    input logic     add_finish,
    input logic     mult_finish,
    input operand_t display_output
);

    int error_count = 0;              // Failed assertions so far

    complete_single: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else begin
            $error("complete stayed high for more than one cycle");
            error_count++;
        end

    start_exclusive: assert property (@(posedge clk) disable iff (!nRST)
        !(add_start && mult_start))
        else begin
            $error("adder and multiplier were started in the same cycle");
            error_count++;
        end

    // Multiplier runs one cycle per operand bit
    mult_latency: assert property (@(posedge clk) disable iff (!nRST)
        mult_start |=> (!mult_finish) [*(WIDTH-1)] ##1 mult_finish)
        else begin
            $error("multiplier finish did not arrive WIDTH cycles after start");
            error_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        !nRST |-> !complete && !add_start && !mult_start && !add_finish
                  && !mult_finish && display_output == '0)
        else begin
            $error("outputs were active while reset was asserted");
            error_count++;
        end

endmodule

//--- dv/calc_tb.sv
`timescale 1ns/1ns

module calc_tb
    import calc_data_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 11;

    logic      clk = 1'b0;
    logic      nRST;
    key_code_t keypad_input;
    op_code_t  operator_input;
    logic      equal_input;
    logic      complete;
    operand_t  display_output;

    integer    seed = 32'hb759_f0bb;
    string     test_name = "reset";
    operand_t  expected = '0;
    logic      complete_allowed = 1'b0;   // Set only while a result is due

    calc_top #(.WIDTH(16)) calc_top_inst (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    // Taps the controller and multiplier nets inside the top level
    bind calc_top calc_props #(.WIDTH(WIDTH)) props_inst (
        .clk            (clk),
        .nRST           (nRST),
        .complete       (complete),
        .add_start      (add_start),
        .mult_start     (mult_start),
        .add_finish     (add_finish),
        .mult_finish    (mult_finish),
        .display_output (display_output)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    check_display: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> display_output == expected)
        else fail_run($sformatf("Error: %s expected %0d actual %0d",
                                test_name, expected, $sampled(display_output)));

    check_pulse_allowed: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> complete_allowed)
        else fail_run($sformatf("%s: complete pulsed with no calculation started", test_name));

    check_display_hold: assert property (@(posedge clk) disable iff (!nRST)
        !complete |-> $stable(display_output))
        else fail_run($sformatf("%s: display changed without a complete pulse", test_name));

    // Expected result straight from the wrap rules
    function automatic operand_t model_result(input op_code_t op, input operand_t a,
                                              input operand_t b);
        case (op)
            OP_ADD:  return operand_t'((32'(a) + 32'(b)) % 32'h1_0000);
            OP_SUB:  return operand_t'((32'h1_0000 + 32'(a) - 32'(b)) % 32'h1_0000);
            default: return operand_t'((32'(a) * 32'(b)) % 32'h1_0000);
        endcase
    endfunction

    function automatic operand_t decode_keys(input key_code_t keys[6]);
        operand_t v;
        v = '0;
        foreach (keys[i]) begin
            if (keys[i] >= 4'd1 && keys[i] <= 4'd9) begin
                v = v * 16'd10 + 16'(keys[i]);
            end else if (keys[i] == 4'd10) begin
                v = v * 16'd10;              // Code 10 is the zero digit
            end
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic hold_key(input key_code_t code, input int cycles);
        keypad_input = code;
        repeat (cycles) next_cycle();
        keypad_input = KEY_NONE;
        repeat (2) next_cycle();
    endtask

    task automatic press_key(input key_code_t code);
        hold_key(code, 2);
    endtask

    task automatic enter_number(input int unsigned n);
        key_code_t digits[$];
        do begin
            digits.push_front((n % 10 == 0) ? KEY_ZERO : key_code_t'(n % 10));
            n = n / 10;
        end while (n != 0);
        foreach (digits[i]) press_key(digits[i]);
    endtask

    task automatic press_operator(input op_code_t op);
        operator_input = op;
        next_cycle();
        operator_input = '0;
        next_cycle();
    endtask

    task automatic press_equal();
        equal_input = 1'b1;
        next_cycle();
        equal_input = 1'b0;
    endtask

    task automatic wait_complete();
        while (complete !== 1'b1) next_cycle();
        next_cycle();                        // Checks sample the pulse on this edge
        complete_allowed = 1'b0;
    endtask

    task automatic run_calc(input string name, input op_code_t op, input operand_t a,
                            input operand_t b);
        test_name = name;
        expected  = model_result(op, a, b);
        enter_number(a);
        press_operator(op);
        enter_number(b);
        complete_allowed = 1'b1;
        press_equal();
        wait_complete();
    endtask

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_TESTS * 200));
        fail_run("Timeout: the calculator did not finish all tests in time");
    end

    // Any bound protocol assertion failing ends the run
    initial begin
        wait (calc_top_inst.props_inst.error_count != 0);
        fail_run("A protocol assertion on the controller or multiplier failed");
    end

    initial begin
        key_code_t mixed[6];
        operand_t  a;
        operand_t  b;
        mixed          = '{4'd4, KEY_ZERO, 4'd12, 4'd7, 4'd15, KEY_ZERO};
        nRST           = 1'b0;
        keypad_input   = KEY_NONE;
        operator_input = '0;
        equal_input    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nRST = 1'b1;
        assert (complete === 1'b0 && display_output === '0)
            else fail_run("Reset did not clear complete and the display");

        for (int i = 0; i < 3; i++) begin
            a = operand_t'($unsigned($random(seed)) % 1000);
            b = operand_t'($unsigned($random(seed)) % 1000);
            run_calc("add_random", OP_ADD, a, b);
        end
        run_calc("sub_wrap", OP_SUB, 16'd12, 16'd345);   // Smaller minus larger
        for (int i = 0; i < 2; i++) begin
            a = operand_t'($unsigned($random(seed)) % 1000);
            b = operand_t'($unsigned($random(seed)) % 1000);
            run_calc("sub_random", OP_SUB, a, b);
        end
        run_calc("mul_overflow", OP_MUL, 16'd999, 16'd999);
        for (int i = 0; i < 2; i++) begin
            a = operand_t'($unsigned($random(seed)) % 1000);
            b = operand_t'($unsigned($random(seed)) % 1000);
            run_calc("mul_random", OP_MUL, a, b);
        end

        // First key held long and codes 12 and 15 ignored
        test_name = "key_coding";
        expected  = model_result(OP_ADD, decode_keys(mixed), 16'd5);
        foreach (mixed[i]) hold_key(mixed[i], (i == 0) ? 8 : 2);
        press_operator(OP_ADD);
        press_key(4'd5);
        complete_allowed = 1'b1;
        press_equal();
        wait_complete();

        test_name = "invalid_op";
        a = operand_t'($unsigned($random(seed)) % 1000);
        b = operand_t'($unsigned($random(seed)) % 1000);
        expected = model_result(OP_SUB, a, b);
        enter_number(a);
        press_operator(3'b011);
        press_equal();                       // Still in the first operand
        repeat (32) next_cycle();            // Longer than any unit latency
        press_operator(OP_SUB);
        enter_number(b);
        complete_allowed = 1'b1;
        press_equal();
        wait_complete();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- files.f
logic/calc_data_pkg.sv
logic/calc_ctrl_pkg.sv
logic/digit_entry.sv
logic/add_sub_unit.sv
logic/seq_multiplier.sv
logic/calc_controller.sv
logic/calc_top.sv
dv/calc_props.sv
dv/calc_tb.sv

//--- logic/add_sub_unit.sv
`timescale 1ns/1ns

module add_sub_unit
    import calc_data_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic     clk,
    input  logic     nRST,
    input  logic     start,
    input  logic     sub,
    input  operand_t in1,
    input  operand_t in2,
    output operand_t result,
    output logic     finish
);

    logic [WIDTH-1:0] sum_diff;

    // Both directions wrap at WIDTH bits
    assign sum_diff = sub ? WIDTH'(in1 - in2) : WIDTH'(in1 + in2);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;                  // Single cycle latency
        end
    end

    // Held until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            result <= sum_diff;
        end
    end

endmodule

//--- logic/calc_controller.sv
`timescale 1ns/1ns

module calc_controller
    import calc_data_pkg::*, calc_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     nRST,
    input  op_code_t operator_input,
    input  logic     equal_input,
    input  logic     add_finish,
    input  logic     mult_finish,
    input  operand_t add_result,
    input  operand_t mult_result,
    output logic     first_enable,
    output logic     second_enable,
    output logic     operand_clear,
    output logic     add_start,
    output logic     sub,
    output logic     mult_start,
    output logic     complete,
    output operand_t display_output
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    op_code_t    op_latched;          // Operator captured at press time
    logic        op_valid;
    logic        is_mult;
    logic        unit_finish;

    assign op_valid    = operator_input inside {OP_ADD, OP_SUB, OP_MUL};
    assign is_mult     = (op_latched == OP_MUL);
    assign unit_finish = is_mult ? mult_finish : add_finish;

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            GET_FIRST: begin
                if (op_valid) begin
                    next_state = GET_SECOND;
                end
            end
            GET_SECOND: begin
                if (equal_input) begin
                    next_state = LAUNCH;
                end
            end
            LAUNCH: begin
                next_state = WAIT_RESULT;
            end
            WAIT_RESULT: begin
                if (unit_finish) begin
                    next_state = SHOW_RESULT;
                end
            end
            SHOW_RESULT: begin
                next_state = GET_FIRST;
            end
            default: begin
                next_state = GET_FIRST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= GET_FIRST;
            op_latched     <= '0;
            add_start      <= 1'b0;
            mult_start     <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state <= next_state;
            if (state == GET_FIRST && op_valid) begin
                op_latched <= operator_input;
            end
            // Only one unit gets the pulse
            add_start  <= (state == LAUNCH) && !is_mult;
            mult_start <= (state == LAUNCH) && is_mult;
            complete   <= (state == SHOW_RESULT);
            if (state == SHOW_RESULT) begin
                display_output <= is_mult ? mult_result : add_result;
            end
        end
    end

    assign first_enable  = (state == GET_FIRST);
    assign second_enable = (state == GET_SECOND);
    assign operand_clear = (state == SHOW_RESULT);   // Operands restart at zero
    assign sub           = (op_latched == OP_SUB);

endmodule

//--- logic/calc_ctrl_pkg.sv
package calc_ctrl_pkg;

    // Controller FSM states
    typedef enum logic [2:0] {
        GET_FIRST   = 3'd0,   // Entering first operand
        GET_SECOND  = 3'd1,   // Entering second operand
        LAUNCH      = 3'd2,   // Fire start pulse
        WAIT_RESULT = 3'd3,   // Wait for unit finish
        SHOW_RESULT = 3'd4    // Load display
    } ctrl_state_t;

endpackage

//--- logic/calc_data_pkg.sv
package calc_data_pkg;

    // Operand, result and display value
    typedef logic [15:0] operand_t;

    // Raw code from the keypad bus
    typedef logic [3:0] key_code_t;

    // Decoded decimal digit, 0 to 9
    typedef logic [3:0] digit_t;

    // One-hot operator select
    typedef logic [2:0] op_code_t;

    localparam op_code_t OP_ADD = 3'b001;
    localparam op_code_t OP_SUB = 3'b010;
    localparam op_code_t OP_MUL = 3'b100;

    localparam key_code_t KEY_NONE = 4'd0;    // No key pressed
    localparam key_code_t KEY_ZERO = 4'd10;   // Digit 0 sits above 1 to 9

endpackage

//--- logic/calc_top.sv
`timescale 1ns/1ns

module calc_top
    import calc_data_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic      clk,
    input  logic      nRST,
    input  key_code_t keypad_input,
    input  op_code_t  operator_input,
    input  logic      equal_input,
    output logic      complete,
    output operand_t  display_output
);

    operand_t first_value;
    operand_t second_value;
    operand_t add_result;
    operand_t mult_result;
    logic     first_enable;
    logic     second_enable;
    logic     operand_clear;
    logic     add_start;
    logic     sub;
    logic     mult_start;
    logic     add_finish;
    logic     mult_finish;

    digit_entry #(.WIDTH(WIDTH)) first_entry_inst (
        .clk          (clk),
        .nRST         (nRST),
        .enable       (first_enable),
        .clear        (operand_clear),
        .keypad_input (keypad_input),
        .value        (first_value)
    );

    digit_entry #(.WIDTH(WIDTH)) second_entry_inst (
        .clk          (clk),
        .nRST         (nRST),
        .enable       (second_enable),
        .clear        (operand_clear),
        .keypad_input (keypad_input),
        .value        (second_value)
    );

    add_sub_unit #(.WIDTH(WIDTH)) add_sub_inst (
        .clk    (clk),
        .nRST   (nRST),
        .start  (add_start),
        .sub    (sub),
        .in1    (first_value),
        .in2    (second_value),
        .result (add_result),
        .finish (add_finish)
    );

    seq_multiplier #(.WIDTH(WIDTH)) mult_inst (
        .clk    (clk),
        .nRST   (nRST),
        .start  (mult_start),
        .in1    (first_value),
        .in2    (second_value),
        .result (mult_result),
        .finish (mult_finish)
    );

    calc_controller ctrl_inst (
        .clk            (clk),
        .nRST           (nRST),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .add_finish     (add_finish),
        .mult_finish    (mult_finish),
        .add_result     (add_result),
        .mult_result    (mult_result),
        .first_enable   (first_enable),
        .second_enable  (second_enable),
        .operand_clear  (operand_clear),
        .add_start      (add_start),
        .sub            (sub),
        .mult_start     (mult_start),
        .complete       (complete),
        .display_output (display_output)
    );

endmodule

//--- logic/digit_entry.sv
`timescale 1ns/1ns

module digit_entry
    import calc_data_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic      clk,
    input  logic      nRST,
    input  logic      enable,
    input  logic      clear,
    input  key_code_t keypad_input,
    output operand_t  value
);

    key_code_t        prev_key;      // Key code seen last cycle
    logic             key_press;
    logic             valid_digit;
    digit_t           digit;
    logic [WIDTH-1:0] acc_next;

    // Only a transition from no key counts as a press
    assign key_press   = (keypad_input != KEY_NONE) && (prev_key == KEY_NONE);
    assign valid_digit = (keypad_input != KEY_NONE) && (keypad_input <= KEY_ZERO);
    assign digit       = (keypad_input == KEY_ZERO) ? digit_t'(0) : digit_t'(keypad_input);

    // Shift one decimal place and add the new digit
    assign acc_next = WIDTH'(value * 10 + digit);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            prev_key <= KEY_NONE;
            value    <= '0;
        end else begin
            prev_key <= keypad_input;
            if (clear) begin
                value <= '0;                  // Clear wins over a key press
            end else if (enable && key_press && valid_digit) begin
                value <= acc_next;
            end
        end
    end

endmodule

//--- logic/seq_multiplier.sv
`timescale 1ns/1ns

module seq_multiplier
    import calc_data_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  logic     clk,
    input  logic     nRST,
    input  logic     start,
    input  operand_t in1,
    input  operand_t in2,
    output operand_t result,
    output logic     finish
);

    localparam int CNT_W = $clog2(WIDTH + 1);

    logic [WIDTH-1:0] mcand;          // Shifts left each step
    logic [WIDTH-1:0] mplier;         // Shifts right each step
    logic [WIDTH-1:0] acc;            // Low bits of partial product
    logic [CNT_W-1:0] count;          // Steps still to run, 0 when idle

    // Control path
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count  <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                count <= CNT_W'(WIDTH - 1);   // Bit 0 handled on load
            end else if (count != '0) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    finish <= 1'b1;           // Last bit done
                end
            end
        end
    end

    // Datapath
    // The load cycle already processes multiplier bit 0, so finish
    // lands exactly WIDTH cycles after start
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= in2[0] ? WIDTH'(in1) : '0;
            mcand  <= WIDTH'(in1) << 1;
            mplier <= WIDTH'(in2) >> 1;
        end else if (count != '0) begin
            if (mplier[0]) begin
                acc <= acc + mcand;           // Wraps modulo 2^WIDTH
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign result = acc;

endmodule
